//--- sim.f
verilog/lsu_pkg.sv
verilog/lsu_request_gen.sv
verilog/lsu_ctrl_queue.sv
verilog/lsu_response_align.sv
verilog/load_store_unit.sv
verification/tb_load_store_unit.sv

//--- Bender.yml
package:
  name: load_store_unit

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_request_gen.sv
      - verilog/lsu_ctrl_queue.sv
      - verilog/lsu_response_align.sv
      - verilog/load_store_unit.sv
  - target: simulation
    files:
      - verification/tb_load_store_unit.sv

//--- verification/tb_load_store_unit.sv
// load/store unit testbench
// drives the execute-stage side of the LSU, models a 16-word data memory
// with random grant delay and in-order responses, and checks bus fields
// and load results against reference functions
`timescale 1ns/10ps

module tb_load_store_unit import lsu_pkg::*; ();

  localparam int RST_CYCLES = 5;
  localparam int N_T1 = 8;    // word store/load pairs
  localparam int N_T2 = 43;   // short loads at every offset and extension
  localparam int N_T3 = 27;   // rotated stores plus read back
  localparam int N_T4 = 8;    // misaligned requests
  localparam int N_T5 = 48;   // random back-to-back traffic
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 200 * (N_T1 + N_T2 + N_T3 + N_T4 + N_T5);

  logic clk = 1'b0;
  logic rst_n;
  logic req_ex_i, we_ex_i, use_incr_i;
  data_type_e type_ex_i;
  sign_ext_e sign_ext_ex_i;
  logic [XLEN-1:0] operand_a_i, operand_b_i, wdata_ex_i;
  logic [OFS_W-1:0] reg_offset_ex_i;
  logic ready_ex_o, misaligned_o;
  logic data_req_o, data_gnt_i, data_we_o, data_rvalid_i;
  logic [XLEN-1:0] data_addr_o, data_wdata_o, data_rdata_i, rdata_o;
  logic [BE_W-1:0] data_be_o;
  logic rdata_valid_o, busy_o;

  integer seed = 32'hbed5;
  logic [XLEN-1:0] mem [16];     // memory model contents
  logic [XLEN-1:0] shadow [16];  // program-order view for expected loads
  int cycle = 0;
  int gnt_wait = 0;              // cycles of requested stall before gnt
  int last_due = -1;
  int rsp_due [$];               // cycle a response may be presented
  logic [XLEN-1:0] rsp_data [$];
  logic [XLEN-1:0] exp_q [$];    // expected load results in issue order
  logic kind_q [$];              // store flag of each accepted transfer
  logic resp_was_store;
  int peak_out = 0;
  int widx, lane, due;
  // fields of the request currently driven
  logic [XLEN-1:0] cur_addr, cur_wdata;
  logic cur_we;
  data_type_e cur_type;
  logic [OFS_W-1:0] cur_rofs;

  load_store_unit u_load_store_unit (.*);

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // failure reporting and reference functions
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int size_bytes(input data_type_e t);
    return (t == TYPE_WORD) ? 4 : (t == TYPE_HALF) ? 2 : 1;
  endfunction

  // lanes ofs .. ofs+size-1 inside the word
  function automatic logic [BE_W-1:0] ref_be(input data_type_e t, input logic [1:0] ofs);
    int i;
    ref_be = '0;
    for (i = 0; i < BE_W; i++)
      if (i >= ofs && i < ofs + size_bytes(t)) ref_be[i] = 1'b1;
  endfunction

  // register byte i lands on lane (i + ofs - rofs) mod 4
  function automatic logic [XLEN-1:0] ref_wdata(input logic [XLEN-1:0] w,
                                                input logic [1:0] ofs, input logic [1:0] rofs);
    int i;
    int dst;
    for (i = 0; i < BE_W; i++) begin
      dst = (i + BE_W + ofs - rofs) % BE_W;
      ref_wdata[8*dst +: 8] = w[8*i +: 8];
    end
  endfunction

  function automatic logic [XLEN-1:0] ref_load(input logic [XLEN-1:0] word, input data_type_e t,
                                               input logic [1:0] ofs, input sign_ext_e ext);
    int i;
    int n;
    logic msb;
    if (t == TYPE_WORD) return word;
    n = size_bytes(t);
    ref_load = '0;
    for (i = 0; i < n; i++) ref_load[8*i +: 8] = word[8*(ofs+i) +: 8];
    msb = ref_load[8*n-1];  // top bit of the payload
    for (i = 8 * n; i < XLEN; i++)
      ref_load[i] = (ext == EXT_SIGN) ? msb : (ext == EXT_ONES);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (data_rvalid_i) begin  // response consumed this edge
      void'(rsp_due.pop_front());
      void'(rsp_data.pop_front());
    end
    if (data_req_o && data_gnt_i) begin
      widx = data_addr_o[5:2];
      rsp_data.push_back(mem[widx]);
      if (data_we_o)
        for (lane = 0; lane < BE_W; lane++)
          if (data_be_o[lane]) mem[widx][8*lane +: 8] = data_wdata_o[8*lane +: 8];
      due = cycle + rand_below(3);  // 1..3 cycles to rvalid
      if (due <= last_due) due = last_due + 1;  // keep acceptance order
      last_due = due;
      rsp_due.push_back(due);
      gnt_wait = rand_below(3);
    end else if (data_req_o && gnt_wait != 0) begin
      gnt_wait = gnt_wait - 1;
    end
  end

  always @(negedge clk) begin
    data_gnt_i = (gnt_wait == 0);
    if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = rsp_data[0];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      check_val("busy_o", busy_o, kind_q.size() != 0);
      if (kind_q.size() >= CTRL_DEPTH) check_val("data_req_o", data_req_o, 1'b0);
      if (data_rvalid_i) begin
        if (kind_q.size() == 0) abort_run("bus response arrived with nothing outstanding");
        resp_was_store = kind_q.pop_front();
        check_val("rdata_valid_o", rdata_valid_o, !resp_was_store);
        if (!resp_was_store) check_val("rdata_o", rdata_o, exp_q.pop_front());
      end else begin
        check_val("rdata_valid_o", rdata_valid_o, 1'b0);
      end
      if (data_req_o && data_gnt_i) begin  // accept
        check_val("data_addr_o", data_addr_o, cur_addr);
        check_val("data_we_o", data_we_o, cur_we);
        check_val("data_be_o", data_be_o, ref_be(cur_type, cur_addr[1:0]));
        if (cur_we)
          check_val("data_wdata_o", data_wdata_o, ref_wdata(cur_wdata, cur_addr[1:0], cur_rofs));
        kind_q.push_back(cur_we);
      end
      if (kind_q.size() > peak_out) peak_out = kind_q.size();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one aligned access issued right after a falling edge
  task automatic do_op(input logic we, input data_type_e t, input sign_ext_e ext,
                       input logic [XLEN-1:0] addr, input logic [XLEN-1:0] wdata,
                       input logic [1:0] rofs);
    int i;
    int b;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wd;
    if (we) begin
      be = ref_be(t, addr[1:0]);
      wd = ref_wdata(wdata, addr[1:0], rofs);
      for (i = 0; i < BE_W; i++)
        if (be[i]) shadow[addr[5:2]][8*i +: 8] = wd[8*i +: 8];
    end else begin
      exp_q.push_back(ref_load(shadow[addr[5:2]], t, addr[1:0], ext));
    end
    use_incr_i = rand_below(2);
    b = rand_below(int'(addr) + 1);
    operand_a_i = use_incr_i ? addr - b : addr;
    operand_b_i = use_incr_i ? b : $random(seed);  // ignored without incr
    req_ex_i = 1'b1;
    we_ex_i = we;
    type_ex_i = t;
    sign_ext_ex_i = ext;
    wdata_ex_i = wdata;
    reg_offset_ex_i = rofs;
    cur_addr = addr;
    cur_we = we;
    cur_type = t;
    cur_wdata = wdata;
    cur_rofs = rofs;
    @(posedge clk);
    check_val("misaligned_o", misaligned_o, 1'b0);
    while (!ready_ex_o) @(posedge clk);  // held until granted
    @(negedge clk);
    req_ex_i = 1'b0;
  endtask

  task automatic misaligned_req(input logic we, input data_type_e t, input logic [XLEN-1:0] addr);
    req_ex_i = 1'b1;
    we_ex_i = we;
    type_ex_i = t;
    use_incr_i = 1'b0;
    operand_a_i = addr;
    @(posedge clk);
    check_val("misaligned_o", misaligned_o, 1'b1);
    check_val("ready_ex_o", ready_ex_o, 1'b1);
    check_val("data_req_o", data_req_o, 1'b0);
    @(negedge clk);
    req_ex_i = 1'b0;
  endtask

  initial begin : main
    int k;
    int o;
    int e;
    int r;
    data_type_e t;
    for (k = 0; k < 16; k++) begin
      mem[k] = (k + 1) * 32'h9e37_79b9;  // distinct per word
      shadow[k] = mem[k];
    end
    rst_n = 1'b0;
    req_ex_i = 1'b0;
    we_ex_i = 1'b0;
    type_ex_i = TYPE_WORD;
    sign_ext_ex_i = EXT_ZERO;
    operand_a_i = '0;
    operand_b_i = '0;
    use_incr_i = 1'b0;
    wdata_ex_i = '0;
    reg_offset_ex_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_val("ready_ex_o", ready_ex_o, 1'b1);

    // word store then load of the same word
    for (k = 0; k < N_T1 / 2; k++) begin
      do_op(1'b1, TYPE_WORD, EXT_ZERO, k * 20, $random(seed), 2'd0);
      do_op(1'b0, TYPE_WORD, EXT_ZERO, k * 20, $random(seed), 2'd0);
    end

    // short loads from a stored word with mixed sign bits and from a fill word
    do_op(1'b1, TYPE_WORD, EXT_ZERO, 32'd12, 32'hf180_7f3c, 2'd0);
    for (k = 0; k < 2; k++)
      for (e = 0; e < 3; e++)
        for (o = 0; o < 4; o++) begin
          do_op(1'b0, TYPE_BYTE, sign_ext_e'(e), (k ? 36 : 12) + o, '0, 2'd0);
          if (o < 3) do_op(1'b0, TYPE_HALF, sign_ext_e'(e), (k ? 36 : 12) + o, '0, 2'd0);
        end

    // stores from a shifted register position and read back of the words
    for (r = 1; r < 4; r++) begin
      for (o = 0; o < 4; o++) do_op(1'b1, TYPE_BYTE, EXT_ZERO, 48 + o, $random(seed), r);
      for (o = 0; o < 3; o++) do_op(1'b1, TYPE_HALF, EXT_ZERO, 52 + o, $random(seed), r);
      do_op(1'b1, TYPE_WORD, EXT_ZERO, 56, $random(seed), r);
    end
    for (k = 12; k < 15; k++) do_op(1'b0, TYPE_WORD, EXT_ZERO, k * 4, '0, 2'd0);

    // misaligned requests that must stay off the bus
    for (k = 0; k < 2; k++) begin
      for (o = 1; o < 4; o++) misaligned_req(k, TYPE_WORD, 32'd20 + o);
      misaligned_req(k, TYPE_HALF, 32'd23);
    end

    // random back-to-back traffic
    for (k = 0; k < N_T5; k++) begin
      t = data_type_e'(rand_below(3));
      o = (t == TYPE_WORD) ? 0 : rand_below(t == TYPE_HALF ? 3 : 4);
      do_op(rand_below(4) == 0, t, sign_ext_e'(rand_below(3)), rand_below(16) * 4 + o,
            $random(seed), rand_below(4));
    end

    while (busy_o) @(negedge clk);  // wait for the last responses
    check_val("exp_q size", exp_q.size(), 0);
    if (peak_out < CTRL_DEPTH) begin
      abort_run("never reached two outstanding transfers");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run("the run timed out before all operations completed");
  end

endmodule

//--- verilog/load_store_unit.sv
// load/store unit top level
// data-memory LSU of the RISC core: request generator feeding the
// req/gnt/rvalid bus, a control queue tracking up to CTRL_DEPTH
// outstanding transfers, and the response aligner for load data
`timescale 1ns/10ps

module load_store_unit import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,

  // execute stage
  input  logic             req_ex_i,
  input  logic             we_ex_i,
  input  data_type_e       type_ex_i,
  input  sign_ext_e        sign_ext_ex_i,
  input  logic [XLEN-1:0]  operand_a_i,
  input  logic [XLEN-1:0]  operand_b_i,
  input  logic             use_incr_i,
  input  logic [XLEN-1:0]  wdata_ex_i,
  input  logic [OFS_W-1:0] reg_offset_ex_i,
  output logic             ready_ex_o,       // ex may advance
  output logic             misaligned_o,

  // data bus
  output logic             data_req_o,
  input  logic             data_gnt_i,
  output logic [XLEN-1:0]  data_addr_o,
  output logic             data_we_o,
  output logic [BE_W-1:0]  data_be_o,
  output logic [XLEN-1:0]  data_wdata_o,
  input  logic             data_rvalid_i,
  input  logic [XLEN-1:0]  data_rdata_i,

  // write back
  output logic [XLEN-1:0]  rdata_o,
  output logic             rdata_valid_o,    // load result this cycle
  output logic             busy_o            // transfers outstanding
);

  logic             queue_full;
  logic             push;        // bus accept
  logic             push_we;
  data_type_e       push_type;
  logic [OFS_W-1:0] push_offset;
  sign_ext_e        push_sign_ext;
  logic             head_we;     // oldest outstanding transfer
  data_type_e       head_type;
  logic [OFS_W-1:0] head_offset;
  sign_ext_e        head_sign_ext;

  lsu_request_gen u_request_gen (
    .req_ex_i        (req_ex_i),
    .we_ex_i         (we_ex_i),
    .type_ex_i       (type_ex_i),
    .sign_ext_ex_i   (sign_ext_ex_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .use_incr_i      (use_incr_i),
    .wdata_ex_i      (wdata_ex_i),
    .reg_offset_ex_i (reg_offset_ex_i),
    .queue_full_i    (queue_full),
    .data_gnt_i      (data_gnt_i),
    .misaligned_o    (misaligned_o),
    .data_req_o      (data_req_o),
    .data_addr_o     (data_addr_o),
    .data_we_o       (data_we_o),
    .data_be_o       (data_be_o),
    .data_wdata_o    (data_wdata_o),
    .push_o          (push),
    .push_we_o       (push_we),
    .push_type_o     (push_type),
    .push_offset_o   (push_offset),
    .push_sign_ext_o (push_sign_ext)
  );

  lsu_ctrl_queue u_ctrl_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .push_i          (push),
    .push_we_i       (push_we),
    .push_type_i     (push_type),
    .push_offset_i   (push_offset),
    .push_sign_ext_i (push_sign_ext),
    .pop_i           (data_rvalid_i),  // one response per accept
    .full_o          (queue_full),
    .busy_o          (busy_o),
    .head_we_o       (head_we),
    .head_type_o     (head_type),
    .head_offset_o   (head_offset),
    .head_sign_ext_o (head_sign_ext)
  );

  lsu_response_align u_response_align (
    .rvalid_i        (data_rvalid_i),
    .rdata_i         (data_rdata_i),
    .head_we_i       (head_we),
    .head_type_i     (head_type),
    .head_offset_i   (head_offset),
    .head_sign_ext_i (head_sign_ext),
    .rdata_o         (rdata_o),
    .rdata_valid_o   (rdata_valid_o)
  );

  // idle, dropped as misaligned, or handed to the bus this cycle
  assign ready_ex_o = ~req_ex_i | misaligned_o | push;

  // an ungranted request stays up with unchanged fields
  a_req_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (data_req_o && !data_gnt_i) |=> data_req_o && $stable(data_addr_o) &&
      $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o));

endmodule

//--- verilog/lsu_response_align.sv
// load/store unit response aligner
// picks the addressed halfword or byte out of the bus response
// using the control of the oldest outstanding transfer and widens
// it with zero, sign or ones fill; words pass through untouched
// combinational from rvalid, stores produce no valid
`timescale 1ns/10ps

module lsu_response_align import lsu_pkg::*; (
  input  logic             rvalid_i,         // bus response strobe
  input  logic [XLEN-1:0]  rdata_i,          // raw bus word
  input  logic             head_we_i,        // oldest transfer was a store
  input  data_type_e       head_type_i,
  input  logic [OFS_W-1:0] head_offset_i,    // first byte lane
  input  sign_ext_e        head_sign_ext_i,

  output logic [XLEN-1:0]  rdata_o,          // to register file
  output logic             rdata_valid_o
);

  logic [XLEN-1:0] lane_data;  // addressed byte moved to lane 0
  logic [XLEN-1:0] half_ext;
  logic [XLEN-1:0] byte_ext;

  // keep the low width bits of val and fill above per mode
  function automatic logic [XLEN-1:0] extend(
    input logic [XLEN-1:0] val,
    input int unsigned     width,
    input sign_ext_e       mode
  );
    logic [XLEN-1:0] keep;  // payload lanes
    logic            top;   // msb of the payload
    keep = {XLEN{1'b1}} >> (XLEN - width);
    top  = val[width-1];
    case (mode)
      EXT_SIGN: extend = (val & keep) | (~keep & {XLEN{top}});
      EXT_ONES: extend = (val & keep) | ~keep;
      default:  extend = val & keep;  // zero fill
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////////////////////////

  // halfwords never sit at offset 3, so the shift never drops payload
  assign lane_data = rdata_i >> {head_offset_i, 3'b000};

  assign half_ext = extend(lane_data, HALF_W, head_sign_ext_i);
  assign byte_ext = extend(lane_data, BYTE_W, head_sign_ext_i);

  //////////////////////////////////////////////////////////////////////
  // size select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (head_type_i)
      TYPE_WORD: rdata_o = rdata_i;   // aligned, no extension
      TYPE_HALF: rdata_o = half_ext;
      default:   rdata_o = byte_ext;
    endcase
  end

  // store responses are consumed silently
  assign rdata_valid_o = rvalid_i & ~head_we_i;

  // head entry must have been written by an earlier push
  a_type_known : assert final (!rvalid_i || !$isunknown(head_type_i))
    else $error("response arrived with undefined access type");

endmodule

//--- verilog/lsu_ctrl_queue.sv
// load/store unit control queue
// small FIFO holding the control of every accepted transfer until
// its response arrives: store flag, size, byte offset, extension
// pushed on bus accept, popped on rvalid, head read combinationally
`timescale 1ns/10ps

module lsu_ctrl_queue import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,

  input  logic             push_i,           // transfer accepted
  input  logic             push_we_i,
  input  data_type_e       push_type_i,
  input  logic [OFS_W-1:0] push_offset_i,
  input  sign_ext_e        push_sign_ext_i,
  input  logic             pop_i,            // response arrived

  output logic             full_o,           // CTRL_DEPTH outstanding
  output logic             busy_o,           // anything outstanding
  output logic             head_we_o,        // oldest transfer
  output data_type_e       head_type_o,
  output logic [OFS_W-1:0] head_offset_o,
  output sign_ext_e        head_sign_ext_o
);

  // payload slots
  logic             we_q     [CTRL_DEPTH];
  data_type_e       type_q   [CTRL_DEPTH];
  logic [OFS_W-1:0] offset_q [CTRL_DEPTH];
  sign_ext_e        sext_q   [CTRL_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;  // next free slot
  logic [PTR_W-1:0] rd_ptr_q;  // oldest slot
  logic [CNT_W-1:0] cnt_q;     // entries in use
  logic             full;
  logic             empty;

  // wrap back to slot 0 after the last slot
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(CTRL_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push_i) begin
      we_q[wr_ptr_q]     <= push_we_i;
      type_q[wr_ptr_q]   <= push_type_i;
      offset_q[wr_ptr_q] <= push_offset_i;
      sext_q[wr_ptr_q]   <= push_sign_ext_i;
    end
  end

  // pointers and count with push and pop in the same cycle allowed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // idle or both
      endcase
    end
  end

  assign full  = (cnt_q == CNT_W'(CTRL_DEPTH));
  assign empty = (cnt_q == '0);

  assign full_o          = full;
  assign busy_o          = ~empty;
  assign head_we_o       = we_q[rd_ptr_q];
  assign head_type_o     = type_q[rd_ptr_q];
  assign head_offset_o   = offset_q[rd_ptr_q];
  assign head_sign_ext_o = sext_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  // generator must hold off requests while every slot is taken
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) (push_i && full) |-> pop_i);

  // rvalid only ever answers an accepted transfer
  a_no_spurious_rvalid : assert property (
    @(posedge clk) disable iff (!rst_n) pop_i |-> !empty);

  a_cnt_bound : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= CNT_W'(CTRL_DEPTH));

endmodule

//--- verilog/lsu_request_gen.sv
// load/store unit request generator
// forms the bus address from the execute-stage operands, flags
// misaligned word/halfword accesses, derives byte enables and
// rotates store data into the addressed lanes; purely combinational
`timescale 1ns/10ps

module lsu_request_gen import lsu_pkg::*; (
  // execute stage side
  input  logic             req_ex_i,         // ld/st request
  input  logic             we_ex_i,          // 1 = store
  input  data_type_e       type_ex_i,        // access size
  input  sign_ext_e        sign_ext_ex_i,    // load extension mode
  input  logic [XLEN-1:0]  operand_a_i,      // base address
  input  logic [XLEN-1:0]  operand_b_i,      // increment
  input  logic             use_incr_i,       // add operand b
  input  logic [XLEN-1:0]  wdata_ex_i,       // store data as in the register
  input  logic [OFS_W-1:0] reg_offset_ex_i,  // byte offset of data in the register

  // control queue
  input  logic             queue_full_i,     // no slot for another transfer

  // bus
  input  logic             data_gnt_i,

  output logic             misaligned_o,     // access not issued
  output logic             data_req_o,
  output logic [XLEN-1:0]  data_addr_o,
  output logic             data_we_o,
  output logic [BE_W-1:0]  data_be_o,
  output logic [XLEN-1:0]  data_wdata_o,

  // entry handed to the control queue on accept
  output logic             push_o,
  output logic             push_we_o,
  output data_type_e       push_type_o,
  output logic [OFS_W-1:0] push_offset_o,
  output sign_ext_e        push_sign_ext_o
);

  logic [XLEN-1:0]   addr;       // effective address
  logic [OFS_W-1:0]  offset;     // byte lane of the first accessed byte
  logic [BE_W-1:0]   size_mask;  // lanes covered at offset 0
  logic [OFS_W-1:0]  wdata_rot;  // store rotation in bytes
  logic [2*XLEN-1:0] wdata_dbl;  // doubled word, upper half is the rotation

  //////////////////////////////////////////////////////////////////////
  // address and alignment
  //////////////////////////////////////////////////////////////////////

  assign addr   = use_incr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offset = addr[OFS_W-1:0];

  // word needs offset 0, halfword must not cross the word boundary
  always_comb begin
    misaligned_o = 1'b0;
    if (req_ex_i) begin
      case (type_ex_i)
        TYPE_WORD: misaligned_o = (offset != '0);
        TYPE_HALF: misaligned_o = (offset == OFS_W'(BE_W - 1));
        default:   misaligned_o = 1'b0;  // bytes fit anywhere
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (type_ex_i)
      TYPE_WORD: size_mask = {BE_W{1'b1}};
      TYPE_HALF: size_mask = BE_W'(2'b11);
      default:   size_mask = BE_W'(1'b1);
    endcase
  end

  // lanes above the top lane fall off the end
  assign data_be_o = size_mask << offset;

  //////////////////////////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////////////////////////

  // register byte reg_offset lands on lane offset modulo the word
  assign wdata_rot    = offset - reg_offset_ex_i;
  assign wdata_dbl    = {wdata_ex_i, wdata_ex_i} << {wdata_rot, 3'b000};
  assign data_wdata_o = wdata_dbl[2*XLEN-1:XLEN];  // rotate left

  //////////////////////////////////////////////////////////////////////
  // bus request and queue push
  //////////////////////////////////////////////////////////////////////

  // request and its fields come straight from the ex stage
  assign data_req_o  = req_ex_i & ~misaligned_o & ~queue_full_i;
  assign data_addr_o = addr;
  assign data_we_o   = we_ex_i;

  assign push_o          = data_req_o & data_gnt_i;  // accept
  assign push_we_o       = we_ex_i;
  assign push_type_o     = type_ex_i;
  assign push_offset_o   = offset;          // response lane select
  assign push_sign_ext_o = sign_ext_ex_i;

  // every access placed on the bus keeps all of its lanes inside the word
  a_no_req_misaligned : assert final (!data_req_o ||
    ($countones(data_be_o) == ((type_ex_i == TYPE_WORD) ? BE_W :
                               (type_ex_i == TYPE_HALF) ? 2 : 1)))
    else $error("misaligned access issued on the data bus");

endmodule

//--- verilog/lsu_pkg.sv
// load/store unit shared definitions
// widths, outstanding-transaction sizing and the access encodings
// exchanged between the execute stage, the request generator,
// the control queue and the response aligner
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////////////////////////

  localparam int XLEN   = 32;            // data and address width
  localparam int BE_W   = XLEN / 8;      // byte lanes per word
  localparam int OFS_W  = $clog2(BE_W);  // byte offset inside a word
  localparam int HALF_W = 16;            // halfword payload width
  localparam int BYTE_W = 8;             // byte payload width

  //////////////////////////////////////////////////////////////////////
  // outstanding transaction bookkeeping
  //////////////////////////////////////////////////////////////////////

  // bus allows this many accepted but unanswered transfers
  localparam int CTRL_DEPTH = 2;
  localparam int CNT_W      = $clog2(CTRL_DEPTH + 1);  // holds 0..CTRL_DEPTH
  localparam int PTR_W      = $clog2(CTRL_DEPTH);      // queue slot index

  //////////////////////////////////////////////////////////////////////
  // access encodings
  //////////////////////////////////////////////////////////////////////

  // access size in the code the core's decoder drives
  typedef enum logic [1:0] {
    TYPE_WORD = 2'b00,  // 32 bit
    TYPE_HALF = 2'b01,  // 16 bit
    TYPE_BYTE = 2'b10   // 8 bit
  } data_type_e;

  // fill of the upper bits for short loads
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,  // lbu / lhu
    EXT_SIGN = 2'b01,  // lb / lh
    EXT_ONES = 2'b10   // ones fill for custom loads
  } sign_ext_e;

  // word loads ignore the extension mode entirely
  // code 2'b11 of data_type_e decodes as a byte access

endpackage
